//--- hdl/soc_io_defines.svh
`ifndef SOC_IO_DEFINES_SVH
`define SOC_IO_DEFINES_SVH

// I/O bus widths
`define SOC_IO_DATA_W 32
`define SOC_IO_ADDR_W 32
`define SOC_IO_STRB_W 4

// Register offsets on the I/O bus
`define SOC_IO_LED_OFS 32'h0000_0000
`define SOC_IO_GPIO_OFS 32'h0000_0004
`define SOC_IO_UART_DATA_OFS 32'h0000_0008
`define SOC_IO_UART_STAT_OFS 32'h0000_000C
`define SOC_IO_BOARD_STAT_OFS 32'h0000_0010

// Short bit time for simulation, board value is clock freq / baud rate
`define SOC_IO_CLKS_PER_BIT 8
`define SOC_IO_FIFO_DEPTH 4

`endif

//--- hdl/soc_io_pkg.sv
`include "soc_io_defines.svh"

package soc_io_pkg;

  typedef logic [`SOC_IO_DATA_W-1:0] io_word_t;

  typedef logic [7:0] uart_byte_t;

  // Write side of the I/O bus
  typedef struct packed {
    logic                      wen;
    logic [`SOC_IO_ADDR_W-1:0] waddr;
    io_word_t                  wdata;
    logic [`SOC_IO_STRB_W-1:0] wstrb;
  } io_wr_t;

  // Read side of the I/O bus
  typedef struct packed {
    logic                      ren;
    logic [`SOC_IO_ADDR_W-1:0] raddr;
  } io_rd_t;

  // Field order gives calib_done in bit 2 and ebreak in bit 0
  typedef struct packed {
    logic calib_done;
    logic clk_locked;
    logic ebreak;
  } board_stat_t;

endpackage

//--- hdl/tx_byte_fifo.sv
module tx_byte_fifo #(
    parameter int DEPTH = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   push,
    input  soc_io_pkg::uart_byte_t push_data,
    input  logic                   pop,
    output soc_io_pkg::uart_byte_t pop_data,
    output logic                   full,
    output logic                   empty
);
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  soc_io_pkg::uart_byte_t mem[DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign full     = (count == CNT_W'(DEPTH));
  assign empty    = (count == '0);
  assign do_pop   = pop && !empty;
  assign do_push  = push && (!full || do_pop);
  // Head of queue is visible before the pop
  assign pop_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  // Neither neighbour may overrun or underrun the queue
  a_no_overflow : assert property (@(posedge clk) disable iff (rst)
      !(push && full && !pop) && !(pop && empty));

endmodule

//--- hdl/uart_tx.sv
`include "soc_io_defines.svh"

module uart_tx (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   empty,
    input  soc_io_pkg::uart_byte_t pop_data,
    output logic                   pop,
    output logic                   busy,
    output logic                   tx
);
  localparam int CLKS = `SOC_IO_CLKS_PER_BIT;
  localparam int CNT_W = (CLKS > 1) ? $clog2(CLKS) : 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_START,
    ST_DATA,
    ST_STOP
  } state_t;

  state_t                 state;
  logic [CNT_W-1:0]       bit_cnt;
  logic [2:0]             bit_idx;
  soc_io_pkg::uart_byte_t data_q;
  logic                   bit_done;

  assign busy     = (state != ST_IDLE);
  assign pop      = (state == ST_IDLE) && !empty;
  assign bit_done = (bit_cnt == CNT_W'(CLKS - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      if (state == ST_IDLE || bit_done) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end

      case (state)
        ST_IDLE: begin
          if (pop) begin
            state <= ST_START;
            tx    <= 1'b0;
          end
        end
        ST_START: begin
          if (bit_done) begin
            state   <= ST_DATA;
            bit_idx <= '0;
            tx      <= data_q[0];
          end
        end
        ST_DATA: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              state <= ST_STOP;
              tx    <= 1'b1;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= data_q[1];
            end
          end
        end
        default: begin
          if (bit_done) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // LSB first, so the byte shifts right once per data bit
  always_ff @(posedge clk) begin
    if (pop) begin
      data_q <= pop_data;
    end else if (state == ST_DATA && bit_done) begin
      data_q <= {1'b0, data_q[7:1]};
    end
  end

  // Line must rest at mark level between frames
  a_idle_high : assert property (@(posedge clk) disable iff (rst) !busy |-> tx);

endmodule

//--- hdl/io_reg_bank.sv
`include "soc_io_defines.svh"

module io_reg_bank (
    input  logic                    clk,
    input  logic                    rst,
    input  soc_io_pkg::io_wr_t      wr,
    input  soc_io_pkg::io_rd_t      rd,
    input  logic                    fifo_full,
    input  logic                    fifo_empty,
    input  logic                    tx_busy,
    input  soc_io_pkg::board_stat_t board_stat,
    output soc_io_pkg::io_word_t    rdata,
    output logic                    push,
    output soc_io_pkg::uart_byte_t  push_data,
    output logic [3:0]              led,
    output soc_io_pkg::io_word_t    gpio
);
  localparam int ADDR_W = `SOC_IO_ADDR_W;
  localparam int DATA_W = `SOC_IO_DATA_W;
  localparam int STRB_W = `SOC_IO_STRB_W;

  logic                 wr_led;
  logic                 wr_gpio;
  logic                 wr_uart;
  soc_io_pkg::io_word_t rd_mux;
  soc_io_pkg::io_word_t uart_stat;

  // Write decode
  assign wr_led  = wr.wen && (wr.waddr == ADDR_W'(`SOC_IO_LED_OFS));
  assign wr_gpio = wr.wen && (wr.waddr == ADDR_W'(`SOC_IO_GPIO_OFS));
  assign wr_uart = wr.wen && (wr.waddr == ADDR_W'(`SOC_IO_UART_DATA_OFS));

  // A byte written into a full FIFO is lost
  assign push      = wr_uart && wr.wstrb[0] && !fifo_full;
  assign push_data = wr.wdata[7:0];

  assign uart_stat = {{(DATA_W - 3){1'b0}}, fifo_empty, tx_busy, fifo_full};

  always_ff @(posedge clk) begin
    if (rst) begin
      led <= '0;
    end else if (wr_led && wr.wstrb[0]) begin
      led <= wr.wdata[3:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gpio <= '0;
    end else if (wr_gpio) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr.wstrb[i]) begin
          gpio[i*8+:8] <= wr.wdata[i*8+:8];
        end
      end
    end
  end

  // Unmapped and write-only offsets read as zero
  always_comb begin
    case (rd.raddr)
      ADDR_W'(`SOC_IO_LED_OFS): begin
        rd_mux = {{(DATA_W - 4){1'b0}}, led};
      end
      ADDR_W'(`SOC_IO_GPIO_OFS): begin
        rd_mux = gpio;
      end
      ADDR_W'(`SOC_IO_UART_STAT_OFS): begin
        rd_mux = uart_stat;
      end
      ADDR_W'(`SOC_IO_BOARD_STAT_OFS): begin
        rd_mux = {{(DATA_W - 3){1'b0}}, board_stat};
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (rd.ren) begin
      rdata <= rd_mux;
    end
  end

  // FIFO never reports full and empty together
  a_fifo_flags : assert property (@(posedge clk) disable iff (rst)
      !(fifo_full && fifo_empty));

endmodule

//--- hdl/soc_io_top.sv
`include "soc_io_defines.svh"

module soc_io_top (
    input  logic                    clk,
    input  logic                    rst,
    input  soc_io_pkg::io_wr_t      wr,
    input  soc_io_pkg::io_rd_t      rd,
    input  soc_io_pkg::board_stat_t board_stat,
    output soc_io_pkg::io_word_t    rdata,
    output logic [3:0]              led,
    output soc_io_pkg::io_word_t    gpio,
    output logic                    uart_tx
);
  logic                   push;
  soc_io_pkg::uart_byte_t push_data;
  logic                   pop;
  soc_io_pkg::uart_byte_t pop_data;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic                   tx_busy;

  io_reg_bank io_regs (
      .clk       (clk),
      .rst       (rst),
      .wr        (wr),
      .rd        (rd),
      .fifo_full (fifo_full),
      .fifo_empty(fifo_empty),
      .tx_busy   (tx_busy),
      .board_stat(board_stat),
      .rdata     (rdata),
      .push      (push),
      .push_data (push_data),
      .led       (led),
      .gpio      (gpio)
  );

  tx_byte_fifo #(
      .DEPTH(`SOC_IO_FIFO_DEPTH)
  ) tx_fifo (
      .clk      (clk),
      .rst      (rst),
      .push     (push),
      .push_data(push_data),
      .pop      (pop),
      .pop_data (pop_data),
      .full     (fifo_full),
      .empty    (fifo_empty)
  );

  uart_tx uart (
      .clk     (clk),
      .rst     (rst),
      .empty   (fifo_empty),
      .pop_data(pop_data),
      .pop     (pop),
      .busy    (tx_busy),
      .tx      (uart_tx)
  );

endmodule

//--- tests/soc_io_tb.sv
`include "soc_io_defines.svh"

module soc_io_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD = 100;
  localparam int CLKS = `SOC_IO_CLKS_PER_BIT;
  localparam int BIT_NS = CLKS * PERIOD;
  // Middle of a bit, shifted onto the falling clock edge
  localparam int MID_NS = BIT_NS / 2 + PERIOD / 2;
  localparam int RAND_WRITES = 8;

  typedef struct packed {
    logic [7:0]                kind;
    logic [`SOC_IO_ADDR_W-1:0] addr;
    soc_io_pkg::io_word_t      data;
    logic [`SOC_IO_STRB_W-1:0] strb;
  } op_t;

  logic                    clk;
  logic                    rst;
  soc_io_pkg::io_wr_t      wr;
  soc_io_pkg::io_rd_t      rd;
  soc_io_pkg::board_stat_t board_stat;
  soc_io_pkg::io_word_t    rdata;
  logic [3:0]              led;
  soc_io_pkg::io_word_t    gpio;
  logic                    uart_tx;

  op_t                    ops[$];
  soc_io_pkg::uart_byte_t exp_q[$];
  logic [3:0]             led_m;
  soc_io_pkg::io_word_t   gpio_m;
  int                     value_errors = 0;
  int                     proto_errors = 0;
  int                     cycles = 0;
  int                     limit = 0;
  int                     n_bytes = 0;
  int                     seed = 32'h0866_c1f1;

  soc_io_top UUT (
      .clk       (clk),
      .rst       (rst),
      .wr        (wr),
      .rd        (rd),
      .board_stat(board_stat),
      .rdata     (rdata),
      .led       (led),
      .gpio      (gpio),
      .uart_tx   (uart_tx)
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  task automatic report_counts();
    $display("Error counts: %0d value mismatches, %0d protocol errors", value_errors,
             proto_errors);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: test did not finish within %0d cycles", limit);
      if (exp_q.size() > 0) begin
        $display("%0d expected UART byte(s) never arrived", exp_q.size());
      end
      proto_errors++;
      report_counts();
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_word(input soc_io_pkg::io_word_t got, input soc_io_pkg::io_word_t exp,
                            input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_byte(input soc_io_pkg::uart_byte_t got,
                            input soc_io_pkg::uart_byte_t exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_led(input logic [3:0] got, input logic [3:0] exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      value_errors++;
      $display("FAILED at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic read_ops();
    int                        fd;
    int                        n;
    int                        c;
    logic [7:0]                kind;
    logic [`SOC_IO_ADDR_W-1:0] a;
    soc_io_pkg::io_word_t      d;
    logic [`SOC_IO_STRB_W-1:0] s;
    logic                      done;
    fd = $fopen("tests/soc_io_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open data file tests/soc_io_input.txt");
      proto_errors++;
      return;
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, " %c", kind);
      a = '0;
      d = '0;
      s = '0;
      if (n != 1) begin
        done = 1'b1;
      end else begin
        case (kind)
          "#": begin
            c = $fgetc(fd);
            while (c != 10 && c != -1) begin
              c = $fgetc(fd);
            end
          end
          "W": n = $fscanf(fd, "%h %h %h", a, d, s);
          "R": n = $fscanf(fd, "%h %h", a, d);
          "S": n = $fscanf(fd, "%h", d);
          "U": begin
            n = $fscanf(fd, "%h", d);
            n_bytes++;
          end
          default: begin
            $display("Unknown operation '%c' in data file", kind);
            proto_errors++;
            done = 1'b1;
          end
        endcase
        if (kind == "W" || kind == "R" || kind == "S" || kind == "U") begin
          ops.push_back('{kind: kind, addr: a, data: d, strb: s});
        end
      end
    end
    $fclose(fd);
  endtask

  // Each bus task starts and ends 10 ns after a rising edge
  task automatic write_bus(input logic [`SOC_IO_ADDR_W-1:0] addr,
                           input soc_io_pkg::io_word_t data,
                           input logic [`SOC_IO_STRB_W-1:0] strb);
    wr.wen   = 1'b1;
    wr.waddr = addr;
    wr.wdata = data;
    wr.wstrb = strb;
    @(posedge clk);
    #10;
    wr.wen = 1'b0;
    if (addr == `SOC_IO_LED_OFS && strb[0]) begin
      led_m = data[3:0];
    end
    if (addr == `SOC_IO_GPIO_OFS) begin
      for (int b = 0; b < `SOC_IO_STRB_W; b++) begin
        if (strb[b]) begin
          gpio_m[b*8+:8] = data[b*8+:8];
        end
      end
    end
    check_led(led, led_m, "led");
    check_word(gpio, gpio_m, "gpio pins");
  endtask

  task automatic read_bus(input logic [`SOC_IO_ADDR_W-1:0] addr,
                          input soc_io_pkg::io_word_t exp);
    rd.ren   = 1'b1;
    rd.raddr = addr;
    @(posedge clk);
    #10;
    rd.ren = 1'b0;
    check_word(rdata, exp, $sformatf("read of %h", addr));
  endtask

  // Serial receiver for the console line
  initial begin : uart_monitor
    soc_io_pkg::uart_byte_t rx;
    soc_io_pkg::uart_byte_t exp_b;
    @(negedge rst);
    forever begin
      @(negedge uart_tx);
      #(MID_NS);
      if (uart_tx !== 1'b0) begin
        proto_errors++;
        $display("UART start bit at %0d ns did not stay low", $time);
      end
      for (int i = 0; i < 8; i++) begin
        #(BIT_NS);
        rx[i] = uart_tx;
      end
      if (exp_q.size() == 0) begin
        proto_errors++;
        $display("UART byte %h arrived at %0d ns but none was expected", rx, $time);
      end else begin
        exp_b = exp_q.pop_front();
        check_byte(rx, exp_b, "UART byte");
      end
      #(BIT_NS);
      if (uart_tx !== 1'b1) begin
        proto_errors++;
        $display("UART stop bit missing after byte %h at %0d ns", rx, $time);
      end
    end
  end

  initial begin
    soc_io_pkg::io_word_t rnd_data;
    soc_io_pkg::io_word_t rnd_strb;
    wr         = '0;
    rd         = '0;
    board_stat = '0;
    rst        = 1'b1;
    led_m      = '0;
    gpio_m     = '0;
    read_ops();
    limit = (ops.size() + 2 * RAND_WRITES) * 4 + n_bytes * 12 * CLKS + 100;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    check_led(led, led_m, "led after reset");
    check_word(gpio, gpio_m, "gpio after reset");
    check_level(uart_tx, 1'b1, "uart_tx after reset");

    foreach (ops[i]) begin
      case (ops[i].kind)
        "W": write_bus(ops[i].addr, ops[i].data, ops[i].strb);
        "R": read_bus(ops[i].addr, ops[i].data);
        "S": begin
          board_stat = ops[i].data[2:0];
          @(posedge clk);
          #10;
        end
        default: exp_q.push_back(ops[i].data[7:0]);
      endcase
    end

    // GPIO byte strobes with random data, readback from the model
    for (int i = 0; i < RAND_WRITES; i++) begin
      rnd_data = $random(seed);
      rnd_strb = $random(seed);
      write_bus(`SOC_IO_GPIO_OFS, rnd_data, rnd_strb[3:0]);
      read_bus(`SOC_IO_GPIO_OFS, gpio_m);
    end

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // Room for a stray frame to show up
    repeat (12 * CLKS) @(posedge clk);
    report_counts();
    if (value_errors + proto_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- tests/soc_io_input.txt
# Columns: W addr data strb | R addr expected | S stat | U expected UART byte
# All values hex; stat bits are calib_done, clk_locked, ebreak
# State after reset
R 00000004 00000000
R 0000000C 00000004
R 00000000 00000000
# LED and GPIO byte strobes
W 00000000 0000000A 1
W 00000000 00000005 2
R 00000000 0000000A
W 00000004 11223344 F
W 00000004 AABBCCDD 5
R 00000004 11BB33DD
W 00000004 00EE0000 A
R 00000004 00BB00DD
# Board status and read-only registers
S 5
R 00000010 00000005
W 00000010 FFFFFFFF F
W 0000000C FFFFFFFF F
R 00000010 00000005
R 0000000C 00000004
S 2
R 00000010 00000002
# Unmapped addresses
W 00000020 FFFFFFFF F
R 00000020 00000000
R 00000014 00000000
R 00000008 00000000
R 00000004 00BB00DD
# UART order, first byte leaves the FIFO at once
U 55
U 0F
U C3
W 00000008 00000055 1
W 00000008 0000000F 1
W 00000008 000000C3 1
R 0000000C 00000002
# Back-pressure, two more fit and the rest are dropped
U 81
U 7E
W 00000008 00000081 1
W 00000008 0000007E 1
W 00000008 000000A5 1
W 00000008 0000005A 1
W 00000008 000000FF 1
R 0000000C 00000003

//--- compile.f
+incdir+hdl
hdl/soc_io_pkg.sv
hdl/tx_byte_fifo.sv
hdl/uart_tx.sv
hdl/io_reg_bank.sv
hdl/soc_io_top.sv
tests/soc_io_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the I/O subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module soc_io_tb --Mdir obj_dir -o soc_io_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/soc_io_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
